// ==== banked_mem.sv ====
`timescale 1ns/10ps

module banked_mem import mem_sys_pkg::*; #(
   parameter int MEM_LATENCY = 2
) (
   input  logic     clk,
   input  logic     rst_n,
   input  mem_req_t req,
   output word_t    rdata
);

   // One bank per word of a line
   localparam int NUM_BANKS  = 1 << WSEL_W;
   // Row bits above the bank select
   localparam int ROW_W      = ADDR_W - WSEL_W - 1;
   localparam int BANK_WORDS = 1 << ROW_W;

   typedef logic [ROW_W-1:0] row_t;

   // Bank storage
   word_t bank_mem [NUM_BANKS][BANK_WORDS];

   // Address decode
   word_sel_t bank;
   row_t      row;

   // Read pipeline
   word_t                  pipe_data [MEM_LATENCY];
   logic [MEM_LATENCY-1:0] pipe_vld;

   assign bank = addr_wsel(req.addr);
   assign row  = req.addr[ADDR_W-1 -: ROW_W];

   //////////////////////////////////////////////////
   // Contents and writes
   //////////////////////////////////////////////////

   // Each word starts out holding its own byte address
   initial begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         for (int r = 0; r < BANK_WORDS; r++) begin
            bank_mem[b][r] = word_t'((r << (WSEL_W + 1)) | (b << 1));
         end
      end
   end

   // Store lands on the strobe edge
   always @(posedge clk) begin
      if (req.wr) begin
         bank_mem[bank][row] <= req.wdata;
      end
   end

   //////////////////////////////////////////////////
   // Fixed latency read
   //////////////////////////////////////////////////

   // Bank data shifts down the pipe, reads overlap
   always_ff @(posedge clk) begin
      if (req.rd) begin
         pipe_data[0] <= bank_mem[bank][row];
      end
      for (int i = 1; i < MEM_LATENCY; i++) begin
         pipe_data[i] <= pipe_data[i-1];
      end
   end

   // Occupancy of each stage
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pipe_vld <= '0;
      end else begin
         pipe_vld[0] <= req.rd;
         for (int i = 1; i < MEM_LATENCY; i++) begin
            pipe_vld[i] <= pipe_vld[i-1];
         end
      end
   end

   // Zero when no read is due
   assign rdata = pipe_vld[MEM_LATENCY-1] ? pipe_data[MEM_LATENCY-1] : '0;

   // Controller never reads and writes together
   a_no_rd_wr : assert property (@(posedge clk) disable iff (!rst_n)
      !(req.rd && req.wr))
      else $error("banked_mem: read and write strobes in the same cycle");

   // Word aligned access only
   a_aligned : assert property (@(posedge clk) disable iff (!rst_n)
      (req.rd || req.wr) |-> (req.addr[0] == 1'b0))
      else $error("banked_mem: odd byte address on a strobe");

endmodule

// ==== build.f ====
mem_sys_pkg.sv
cache_way.sv
banked_mem.sv
cache_ctrl.sv
mem_system.sv
tb_mem_system.sv

// ==== cache_ctrl.sv ====
`timescale 1ns/10ps

module cache_ctrl import mem_sys_pkg::*; #(
   parameter int MEM_LATENCY = 2
) (
   input  logic      clk,
   input  logic      rst_n,
   input  cpu_req_t  cpu_req,
   input  way_stat_t way0_stat,
   input  way_stat_t way1_stat,
   input  word_t     mem_rdata,
   output way_cmd_t  way0_cmd,
   output way_cmd_t  way1_cmd,
   output mem_req_t  mem_req,
   output word_t     data_out,
   output logic      done,
   output logic      stall,
   output logic      cache_hit
);

   // Fill issues every word then drains the memory pipe
   localparam int FILL_CYCLES = LINE_WORDS + MEM_LATENCY;
   localparam int CNT_W       = $clog2(FILL_CYCLES + 1);

   typedef logic [CNT_W-1:0] cnt_t;

   // FSM
   ctrl_state_t state;
   ctrl_state_t state_nxt;

   // Captured request
   cpu_req_t  req_q;
   tag_t      req_tag;
   index_t    req_index;
   word_sel_t req_wsel;

   // Replacement
   logic victim_q;
   logic way_sel_q;
   logic choose_way;
   logic victim_dirty;

   // Word counter
   cnt_t cnt;
   cnt_t ret_idx;
   logic cnt_clr;
   logic cnt_inc;

   // Way side helpers
   logic      accept;
   logic      any_hit;
   word_t     hit_rdata;
   way_stat_t sel_stat;
   way_cmd_t  cmd;
   logic [1:0] way_en;

   //////////////////////////////////////////////////
   // Request capture and victim bit
   //////////////////////////////////////////////////

   // Only taken while not stalled
   assign accept = (state == IDLE) && (cpu_req.rd || cpu_req.wr);

   // Read wins a tie
   always_ff @(posedge clk) begin
      if (accept) begin
         req_q.rd    <= cpu_req.rd;
         req_q.wr    <= cpu_req.wr && !cpu_req.rd;
         req_q.addr  <= cpu_req.addr;
         req_q.wdata <= cpu_req.wdata;
      end
   end

   assign req_tag   = addr_tag(req_q.addr);
   assign req_index = addr_index(req_q.addr);
   assign req_wsel  = addr_wsel(req_q.addr);

   // State, victim toggle, chosen way, counter
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= IDLE;
         victim_q  <= 1'b0;
         way_sel_q <= 1'b0;
         cnt       <= '0;
      end else begin
         state <= state_nxt;
         if (accept) begin
            victim_q <= ~victim_q;
         end
         // Way choice frozen for the rest of the miss
         if (state == LOOKUP) begin
            way_sel_q <= choose_way;
         end
         if (cnt_clr) begin
            cnt <= '0;
         end else if (cnt_inc) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Way choice and lookup results
   //////////////////////////////////////////////////

   // Empty way first, way 0 ahead of way 1
   always_comb begin
      if (!way0_stat.valid) begin
         choose_way = 1'b0;
      end else if (!way1_stat.valid) begin
         choose_way = 1'b1;
      end else begin
         choose_way = victim_q;
      end
   end

   // Line to evict needs a write-back
   assign victim_dirty = choose_way ? (way1_stat.valid && way1_stat.dirty)
                                    : (way0_stat.valid && way0_stat.dirty);

   assign any_hit   = way0_stat.hit || way1_stat.hit;
   assign hit_rdata = way1_stat.hit ? way1_stat.rdata : way0_stat.rdata;
   assign sel_stat  = way_sel_q ? way1_stat : way0_stat;

   // Line word due back from memory this cycle
   assign ret_idx = cnt - cnt_t'(MEM_LATENCY);

   //////////////////////////////////////////////////
   // Miss handling FSM
   //////////////////////////////////////////////////

   always_comb begin
      state_nxt    = state;
      cnt_clr      = 1'b0;
      cnt_inc      = 1'b0;
      way_en       = 2'b00;
      cmd          = '0;
      cmd.tag      = req_tag;
      cmd.index    = req_index;
      cmd.word_sel = req_wsel;
      cmd.wdata    = req_q.wdata;
      mem_req      = '0;
      data_out     = '0;
      done         = 1'b0;
      cache_hit    = 1'b0;
      stall        = 1'b1;

      case (state)
         IDLE: begin
            stall   = 1'b0;
            cnt_clr = 1'b1;
            if (accept) begin
               state_nxt = LOOKUP;
            end
         end

         LOOKUP: begin
            // Compare access on both ways
            way_en    = 2'b11;
            cmd.comp  = 1'b1;
            cmd.write = req_q.wr;
            if (any_hit) begin
               done      = 1'b1;
               cache_hit = 1'b1;
               if (req_q.rd) begin
                  data_out = hit_rdata;
               end
               state_nxt = IDLE;
            end else if (victim_dirty) begin
               state_nxt = WRITEBACK;
            end else begin
               state_nxt = FILL;
            end
         end

         WRITEBACK: begin
            // Old line out one word per cycle
            way_en[way_sel_q] = 1'b1;
            cmd.word_sel      = cnt[WSEL_W-1:0];
            mem_req.wr        = 1'b1;
            mem_req.addr      = make_addr(sel_stat.tag, req_index, cnt[WSEL_W-1:0]);
            mem_req.wdata     = sel_stat.rdata;
            if (cnt == cnt_t'(LINE_WORDS - 1)) begin
               cnt_clr   = 1'b1;
               state_nxt = FILL;
            end else begin
               cnt_inc = 1'b1;
            end
         end

         FILL: begin
            cnt_inc = 1'b1;
            // Back to back reads of the new line
            if (cnt < cnt_t'(LINE_WORDS)) begin
               mem_req.rd   = 1'b1;
               mem_req.addr = make_addr(req_tag, req_index, cnt[WSEL_W-1:0]);
            end
            // Returned words go straight into the chosen way
            if (cnt >= cnt_t'(MEM_LATENCY)) begin
               way_en[way_sel_q] = 1'b1;
               cmd.write         = 1'b1;
               cmd.valid_in      = 1'b1;
               cmd.word_sel      = ret_idx[WSEL_W-1:0];
               cmd.wdata         = mem_rdata;
            end
            if (cnt == cnt_t'(FILL_CYCLES - 1)) begin
               cnt_clr   = 1'b1;
               state_nxt = FINISH;
            end
         end

         FINISH: begin
            // Compare access again so a store sets dirty
            way_en[way_sel_q] = 1'b1;
            cmd.comp          = 1'b1;
            cmd.write         = req_q.wr;
            done              = 1'b1;
            if (req_q.rd) begin
               data_out = sel_stat.rdata;
            end
            state_nxt = IDLE;
         end

         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   // Same command to both ways with separate enables
   always_comb begin
      way0_cmd    = cmd;
      way0_cmd.en = way_en[0];
      way1_cmd    = cmd;
      way1_cmd.en = way_en[1];
   end

   // Two lines of one set never share a tag
   a_single_hit : assert property (@(posedge clk) disable iff (!rst_n)
      (state == LOOKUP) |-> !(way0_stat.hit && way1_stat.hit))
      else $error("cache_ctrl: both ways hit in one set");

   // Refilled line is present when the miss finishes
   a_finish_hit : assert property (@(posedge clk) disable iff (!rst_n)
      (state == FINISH) |-> sel_stat.hit)
      else $error("cache_ctrl: refilled line missed in FINISH");

endmodule

// ==== cache_way.sv ====
`timescale 1ns/10ps

module cache_way import mem_sys_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   input  way_cmd_t  cmd,
   output way_stat_t stat
);

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   // Tag and data arrays
   tag_t  tag_mem  [NUM_SETS];
   word_t data_mem [NUM_SETS][LINE_WORDS];

   // Per set state bits cleared at reset
   logic [NUM_SETS-1:0] valid_q;
   logic [NUM_SETS-1:0] dirty_q;

   // Write qualifiers
   logic wr_en;
   logic cmp_wr;
   logic fill_wr;

   //////////////////////////////////////////////////
   // Status lookup
   //////////////////////////////////////////////////

   // Pure read of the addressed set
   always_comb begin
      stat.valid = valid_q[cmd.index];
      stat.dirty = dirty_q[cmd.index];
      stat.tag   = tag_mem[cmd.index];
      // Hit needs a valid line and matching tag
      stat.hit   = valid_q[cmd.index] && (tag_mem[cmd.index] == cmd.tag);
      stat.rdata = data_mem[cmd.index][cmd.word_sel];
   end

   //////////////////////////////////////////////////
   // Write paths
   //////////////////////////////////////////////////

   assign wr_en   = cmd.en && cmd.write;
   // Compare write only lands on a hit
   assign cmp_wr  = wr_en && cmd.comp && stat.hit;
   // Fill write from the line refill
   assign fill_wr = wr_en && !cmd.comp;

   // Word store for either write kind
   always_ff @(posedge clk) begin
      if (cmp_wr || fill_wr) begin
         data_mem[cmd.index][cmd.word_sel] <= cmd.wdata;
      end
      // Tag only follows a fill
      if (fill_wr) begin
         tag_mem[cmd.index] <= cmd.tag;
      end
   end

   // Valid and dirty bookkeeping
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         if (fill_wr) begin
            // Freshly filled line is clean
            valid_q[cmd.index] <= cmd.valid_in;
            dirty_q[cmd.index] <= 1'b0;
         end else if (cmp_wr) begin
            // CPU store marks the line dirty
            dirty_q[cmd.index] <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // Every refill word installs a valid line
   a_fill_sets_valid : assert property (@(posedge clk) disable iff (!rst_n)
      fill_wr |-> cmd.valid_in)
      else $error("cache_way: fill write without valid_in");

endmodule

// ==== mem_sys_pkg.sv ====
package mem_sys_pkg;

   //////////////////////////////////////////////////
   // Address and data geometry
   //////////////////////////////////////////////////

   // CPU byte address and data word
   localparam int ADDR_W     = 16;
   localparam int WORD_W     = 16;
   // Address fields above the byte bit
   localparam int TAG_W      = 5;
   localparam int INDEX_W    = 8;
   localparam int WSEL_W     = 2;
   // Words per cache line
   localparam int LINE_WORDS = 4;
   localparam int NUM_SETS   = 1 << INDEX_W;

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [WORD_W-1:0]  word_t;
   typedef logic [TAG_W-1:0]   tag_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [WSEL_W-1:0]  word_sel_t;

   //////////////////////////////////////////////////
   // Bundles between blocks
   //////////////////////////////////////////////////

   // CPU request, strobes valid for one cycle
   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      word_t wdata;
   } cpu_req_t;

   // Word request to the banked memory
   typedef struct packed {
      logic  rd;
      logic  wr;
      addr_t addr;
      word_t wdata;
   } mem_req_t;

   // Command into one cache way
   typedef struct packed {
      logic      en;
      logic      comp;
      logic      write;
      logic      valid_in;
      tag_t      tag;
      index_t    index;
      word_sel_t word_sel;
      word_t     wdata;
   } way_cmd_t;

   // Status out of one cache way
   typedef struct packed {
      logic  hit;
      logic  valid;
      logic  dirty;
      tag_t  tag;
      word_t rdata;
   } way_stat_t;

   // Miss handling FSM
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      WRITEBACK,
      FILL,
      FINISH
   } ctrl_state_t;

   // Field slicing of a byte address
   function automatic tag_t addr_tag(addr_t a);
      return a[ADDR_W-1 -: TAG_W];
   endfunction

   function automatic index_t addr_index(addr_t a);
      return a[WSEL_W+INDEX_W : WSEL_W+1];
   endfunction

   function automatic word_sel_t addr_wsel(addr_t a);
      return a[WSEL_W:1];
   endfunction

   // Word address rebuilt from its fields, byte bit zero
   function automatic addr_t make_addr(tag_t t, index_t i, word_sel_t w);
      return {t, i, w, 1'b0};
   endfunction

endpackage

// ==== mem_system.sv ====
`timescale 1ns/10ps

module mem_system import mem_sys_pkg::*; #(
   // Read latency of the banked memory in cycles
   parameter int MEM_LATENCY = 2
) (
   input  logic     clk,
   input  logic     rst_n,
   input  cpu_req_t cpu_req,
   output word_t    data_out,
   output logic     done,
   output logic     stall,
   output logic     cache_hit
);

   //////////////////////////////////////////////////
   // Internal buses
   //////////////////////////////////////////////////

   // Controller to ways
   way_cmd_t  way0_cmd;
   way_cmd_t  way1_cmd;
   way_stat_t way0_stat;
   way_stat_t way1_stat;

   // Controller to memory
   mem_req_t mem_req;
   word_t    mem_rdata;

   // Request capture and miss sequencing
   cache_ctrl #(
      .MEM_LATENCY (MEM_LATENCY)
   ) ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .cpu_req   (cpu_req),
      .way0_stat (way0_stat),
      .way1_stat (way1_stat),
      .mem_rdata (mem_rdata),
      .way0_cmd  (way0_cmd),
      .way1_cmd  (way1_cmd),
      .mem_req   (mem_req),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit)
   );

   // Two ways of the set
   cache_way way0 (
      .clk   (clk),
      .rst_n (rst_n),
      .cmd   (way0_cmd),
      .stat  (way0_stat)
   );

   cache_way way1 (
      .clk   (clk),
      .rst_n (rst_n),
      .cmd   (way1_cmd),
      .stat  (way1_stat)
   );

   // Backing store
   banked_mem #(
      .MEM_LATENCY (MEM_LATENCY)
   ) mem (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (mem_req),
      .rdata (mem_rdata)
   );

endmodule

// ==== mem_system_input.txt ====
# op: R read, W write, an S suffix adds stray writes while stalled; then addr, wdata (hex)
# then expected read data (hex), expected hit, expected cycles from acceptance to done
RS 0010 0000 0010 0 8
R  0016 0000 0016 1 1
W  0014 1234 0000 1 1
RS 0014 0000 1234 1 1
WS 4824 beef 0000 0 8
R  4824 0000 beef 1 1
R  4820 0000 4820 1 1
R  0810 0000 0810 0 8
R  0812 0000 0812 1 1
RS 1012 0000 1012 0 12
R  0014 0000 1234 0 8
R  0010 0000 0010 1 1
W  2822 5a5a 0000 0 8
R  2822 0000 5a5a 1 1
RS 3024 0000 3024 0 12
R  4824 0000 beef 1 1
R  2822 0000 5a5a 0 8
R  2820 0000 2820 1 1
W  2826 0f0f 0000 1 1
RS fffe 0000 fffe 0 8
R  fffe 0000 fffe 1 1
R  2826 0000 0f0f 1 1

// ==== tb_mem_system.sv ====
`timescale 1ns/10ps

module tb_mem_system import mem_sys_pkg::*; ();

   // Clock and drive timing
   localparam int CLK_HALF          = 10;
   localparam int DRIVE_DLY         = 1;
   localparam int TIMEOUT_CYCLES    = 50;
   localparam int IDLE_CHECK_CYCLES = 4;
   // Data of an ignored request, would show up on a later read
   localparam logic [15:0] STRAY_DATA = 16'hdead;

   logic     clk;
   logic     rst_n;
   cpu_req_t cpu_req;
   word_t    data_out;
   logic     done;
   logic     stall;
   logic     cache_hit;

   // Bookkeeping
   int error_count;
   int check_count;
   int timeout_count;
   int done_count;

   mem_system #(
      .MEM_LATENCY (2)
   ) UUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .cpu_req   (cpu_req),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit)
   );

   //////////////////////////////////////////////////
   // Clock and done monitor
   //////////////////////////////////////////////////

   always #(CLK_HALF) clk = ~clk;

   // Every done pulse, sampled mid cycle
   always @(negedge clk) begin
      if (rst_n && done) begin
         done_count++;
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // Stray write while busy, or nothing
   task automatic drive_stray(input logic enable, input addr_t addr);
      cpu_req = '0;
      if (enable) begin
         cpu_req.wr    = 1'b1;
         cpu_req.addr  = addr;
         cpu_req.wdata = STRAY_DATA;
      end
   endtask

   // Polls stall 1 ns after each edge
   task automatic wait_idle(output logic ok);
      int cycles;
      cycles = 0;
      while (stall && cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         #(DRIVE_DLY);
         cycles++;
      end
      ok = !stall;
      if (!ok) begin
         $display("Timeout: stall stayed high for %0d cycles", TIMEOUT_CYCLES);
      end
   endtask

   // One request, strobe held for a single cycle
   task automatic issue_request(input logic is_read, input logic strays,
                                input addr_t addr, input word_t wdata,
                                output logic ok, output word_t rdata,
                                output logic hit, output int cycles);
      logic seen;
      seen   = 1'b0;
      cycles = 0;
      rdata  = '0;
      hit    = 1'b0;
      cpu_req.rd    = is_read;
      cpu_req.wr    = !is_read;
      cpu_req.addr  = addr;
      cpu_req.wdata = wdata;
      // Accepting edge
      @(posedge clk);
      #(DRIVE_DLY);
      drive_stray(strays && stall, addr);
      // Cycle 1 is the lookup cycle
      while (!seen && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
         if (done) begin
            seen  = 1'b1;
            rdata = data_out;
            hit   = cache_hit;
         end
         @(posedge clk);
         #(DRIVE_DLY);
         // Strays only while the controller is busy
         drive_stray(strays && !seen && stall, addr);
      end
      ok = seen;
      if (!seen) begin
         $display("Timeout: no done within %0d cycles for address %h",
                  TIMEOUT_CYCLES, addr);
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      int              fd;
      int              n;
      int              req_no;
      int              exp_hit;
      int              exp_lat;
      int              cycles;
      logic            run_ok;
      logic            ok;
      logic            is_read;
      logic            strays;
      logic            hit;
      word_t           rdata;
      logic [15:0]     addr_v;
      logic [15:0]     wdata_v;
      logic [15:0]     exp_data;
      reg [8*4-1:0]    op_str;
      reg [8*128-1:0]  line_buf;

      clk           = 1'b0;
      rst_n         = 1'b0;
      cpu_req       = '0;
      error_count   = 0;
      check_count   = 0;
      timeout_count = 0;
      done_count    = 0;
      req_no        = 0;
      run_ok        = 1'b1;

      // Two cycles of reset
      repeat (2) @(posedge clk);
      #(DRIVE_DLY);
      rst_n = 1'b1;

      // Quiet outputs with no request
      for (int i = 0; i < IDLE_CHECK_CYCLES; i++) begin
         @(negedge clk);
         check_value("reset idle stall", 0, stall);
         check_value("reset idle done", 0, done);
         check_value("reset idle cache_hit", 0, cache_hit);
      end
      @(posedge clk);
      #(DRIVE_DLY);

      fd = $fopen("mem_system_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file mem_system_input.txt");
         run_ok = 1'b0;
      end else begin
         while (run_ok && $fgets(line_buf, fd) != 0) begin
            n = $sscanf(line_buf, "%s %h %h %h %d %d", op_str, addr_v, wdata_v,
                        exp_data, exp_hit, exp_lat);
            // Comment or blank line
            if (n != 6 || op_str == "#") begin
               continue;
            end
            req_no++;
            is_read = (op_str == "R") || (op_str == "RS");
            strays  = (op_str == "RS") || (op_str == "WS");
            if (!is_read && op_str != "W" && op_str != "WS") begin
               $display("Unknown operation in stimulus request %0d", req_no);
               error_count++;
               continue;
            end
            wait_idle(ok);
            if (ok) begin
               issue_request(is_read, strays, addr_v, wdata_v, ok, rdata, hit, cycles);
            end
            if (!ok) begin
               timeout_count++;
               run_ok = 1'b0;
            end else begin
               if (is_read) begin
                  check_value($sformatf("req %0d data", req_no), exp_data, rdata);
               end
               check_value($sformatf("req %0d hit", req_no), exp_hit, hit);
               check_value($sformatf("req %0d cycles", req_no), exp_lat, cycles);
            end
         end
         $fclose(fd);
      end

      if (run_ok && req_no == 0) begin
         $display("The stimulus file held no requests");
         run_ok = 1'b0;
      end

      // Late pulses from an accepted stray would land here
      repeat (IDLE_CHECK_CYCLES) @(posedge clk);
      if (run_ok) begin
         check_value("done pulse count", req_no, done_count);
      end

      $display("Checks: %0d, errors: %0d, timeouts: %0d, requests: %0d, done pulses: %0d",
               check_count, error_count, timeout_count, req_no, done_count);
      if (run_ok && error_count == 0 && timeout_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
